/* verilog.f */
verilog/pecPkg.sv
verilog/weightRegs.sv
verilog/actSequencer.sv
verilog/convRow.sv
verilog/psumCtrl.sv
verilog/pecTop.sv
dv/pecClkGen.sv
dv/pecTop_chk.sv
dv/pecTb.sv

/* Makefile */
# Verilator build of the PE cluster testbench
SIM := obj_dir/pecSim
LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module pecTb \
		-f verilog.f -Mdir obj_dir -o pecSim

# The simulator's exit status is ignored, the log decides pass or fail
run: compile
	-./$(SIM) > $(LOG) 2>&1
	cat $(LOG)
	grep -qx "TEST PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* dv/pecTb.sv */
// Two layers of three full rows each; RAM model answers reads after one cycle, no bypass
`timescale 1ns/10ps
`default_nettype none

module pecTb;

    logic                clk;
    logic                rst_n;
    logic                wtValid   = 1'b0;
    pecPkg::kernelT      wtData    = '0;
    logic                wtReady;
    logic                actValid  = 1'b0;
    pecPkg::vecT         actData   = '0;
    logic                actLast   = 1'b0;
    logic                actReady;
    logic                nxtValid;
    pecPkg::vecT         nxtData;
    logic                nxtLast;
    logic                nxtReady  = 1'b0;
    logic                ramRdEn;
    pecPkg::addrT        ramRdAddr;
    pecPkg::psumT        ramRdData = '0;
    logic                ramWrEn;
    pecPkg::addrT        ramWrAddr;
    pecPkg::psumT        ramWrData;

    integer              seed;
    pecPkg::psumT        ramMem [pecPkg::OutCols];
    // Reference side
    pecPkg::psumT        refMem [pecPkg::OutCols];
    pecPkg::kernelT      refKernel;
    pecPkg::vecT         rowBuf [pecPkg::RowActs];
    logic [32:0]         fwdQ [$];
    pecPkg::psumT        deltaQ [$];
    pecPkg::addrT        addrQ [$];
    logic                tbLoaded  = 1'b0;
    int                  colIdx    = 0;
    int                  cycles    = 0;

    pecClkGen i_pecClkGen (.clk(clk), .rst_n(rst_n));

    pecTop i_pecTop (
        .clk(clk), .rst_n(rst_n),
        .wtValid(wtValid), .wtData(wtData), .wtReady(wtReady),
        .actValid(actValid), .actData(actData), .actLast(actLast), .actReady(actReady),
        .nxtValid(nxtValid), .nxtData(nxtData), .nxtLast(nxtLast), .nxtReady(nxtReady),
        .ramRdEn(ramRdEn), .ramRdAddr(ramRdAddr), .ramRdData(ramRdData),
        .ramWrEn(ramWrEn), .ramWrAddr(ramWrAddr), .ramWrData(ramWrData)
    );

    bind pecTop pecTop_chk i_pecTopChk (
        .clk(clk), .rst_n(rst_n), .wtReady(wtReady),
        .actValid(actValid), .actReady(actReady),
        .nxtValid(nxtValid), .nxtData(nxtData), .nxtLast(nxtLast), .nxtReady(nxtReady),
        .ramRdEn(ramRdEn), .ramRdAddr(ramRdAddr), .ramWrEn(ramWrEn)
    );

    // ========================================================================
    // Helpers
    // ========================================================================

    task automatic failNow(input string msg);
        $display("%s", msg);
        $display("TEST FAIL");
        $fatal(1, "Stopping at first error");
    endtask

    function automatic logic randBit();
        return ($random(seed) % 2) != 0;
    endfunction

    // Signed dot product of two vectors
    function automatic pecPkg::psumT dotVec(input pecPkg::vecT a, input pecPkg::vecT b);
        int sum;
        sum = 0;
        for (int e = 0; e < pecPkg::BlockDepth; e++) begin
            sum = sum + $signed(a[e*pecPkg::DataW +: pecPkg::DataW])
                      * $signed(b[e*pecPkg::DataW +: pecPkg::DataW]);
        end
        return pecPkg::psumT'(sum);
    endfunction

    // Nine-tap sum ending at column k of the current row
    function automatic pecPkg::psumT windowSum(input int k);
        pecPkg::psumT acc;
        acc = '0;
        for (int t = 0; t < pecPkg::NumTaps; t++) begin
            acc = acc + dotVec(refKernel[t], rowBuf[k - (pecPkg::NumTaps - 1) + t]);
        end
        return acc;
    endfunction

    task automatic loadKernel();
        pecPkg::kernelT kern;
        for (int t = 0; t < pecPkg::NumTaps; t++) begin
            kern[t] = pecPkg::vecT'($random(seed));
        end
        wtData  <= kern;
        wtValid <= 1'b1;
        @(posedge clk);
        while (!wtReady) @(posedge clk);
        wtValid <= 1'b0;
    endtask

    // Hold data until accepted, valid raised at random
    task automatic sendAct(input pecPkg::vecT data, input logic last);
        actData  <= data;
        actLast  <= last;
        actValid <= randBit();
        @(posedge clk);
        while (!(actValid && actReady)) begin
            if (!actValid) begin
                actValid <= randBit();
            end
            @(posedge clk);
        end
    endtask

    // ========================================================================
    // Environment: next-cluster back-pressure and psum RAM
    // ========================================================================

    always @(posedge clk) begin
        nxtReady <= randBit();
    end

    always @(posedge clk) begin
        if (ramRdEn) begin
            ramRdData <= ramMem[ramRdAddr];
        end
        if (ramWrEn) begin
            ramMem[ramWrAddr] <= ramWrData;
        end
    end

    // ========================================================================
    // Monitor and reference model
    // ========================================================================

    always @(posedge clk) begin
        logic [32:0]  expFwd;
        pecPkg::addrT expAddr;
        pecPkg::psumT expData;
        cycles = cycles + 1;
        // 96 activations at ~25% throughput need under 400 cycles
        if (cycles > 2000) begin
            failNow("Timeout: the run did not finish within 2000 cycles");
        end
        if (rst_n) begin
            // No activations while the cluster waits for weights
            if (!tbLoaded) begin
                assert (wtReady) else failNow($sformatf(
                    "MISMATCH at %0t: wtReady expected 1 got %b", $time, wtReady));
                assert (!actReady) else failNow($sformatf(
                    "MISMATCH at %0t: actReady expected 0 got %b", $time, actReady));
            end
            if (wtValid && wtReady) begin
                refKernel = wtData;
                tbLoaded  = 1'b1;
            end
            if (nxtValid && nxtReady) begin
                assert (fwdQ.size() > 0)
                    else failNow("Next cluster got an activation that was never accepted");
                expFwd = fwdQ.pop_front();
                assert (nxtData == expFwd[31:0]) else failNow($sformatf(
                    "MISMATCH at %0t: nxtData expected %h got %h", $time, expFwd[31:0], nxtData));
                assert (nxtLast == expFwd[32]) else failNow($sformatf(
                    "MISMATCH at %0t: nxtLast expected %b got %b", $time, expFwd[32], nxtLast));
            end
            if (actValid && actReady) begin
                fwdQ.push_back({actLast, actData});
                rowBuf[colIdx] = actData;
                if (colIdx >= pecPkg::NumTaps - 1) begin
                    deltaQ.push_back(windowSum(colIdx));
                    addrQ.push_back(pecPkg::addrT'(colIdx - (pecPkg::NumTaps - 1)));
                end
                colIdx = (colIdx == pecPkg::RowActs - 1) ? 0 : colIdx + 1;
                if (actLast) begin
                    tbLoaded = 1'b0;
                end
            end
            if (ramWrEn) begin
                assert (deltaQ.size() > 0)
                    else failNow("RAM write issued with no full window pending");
                expAddr = addrQ.pop_front();
                expData = refMem[expAddr] + deltaQ.pop_front();
                assert (ramWrAddr == expAddr) else failNow($sformatf(
                    "MISMATCH at %0t: ramWrAddr expected %0d got %0d", $time, expAddr, ramWrAddr));
                assert (ramWrData == expData) else failNow($sformatf(
                    "MISMATCH at %0t: ramWrData expected %h got %h", $time, expData, ramWrData));
                refMem[expAddr] = expData;
            end
        end
    end

    // ========================================================================
    // Stimulus
    // ========================================================================

    initial begin
        pecPkg::psumT word;
        seed = 51;
        for (int i = 0; i < pecPkg::OutCols; i++) begin
            word      = pecPkg::psumT'($random(seed));
            ramMem[i] <= word;
            refMem[i] = word;
        end
        @(posedge rst_n);
        @(posedge clk);
        for (int layer = 0; layer < 2; layer++) begin
            loadKernel();
            for (int row = 0; row < 3; row++) begin
                for (int col = 0; col < pecPkg::RowActs; col++) begin
                    sendAct(pecPkg::vecT'($random(seed)),
                            (row == 2) && (col == pecPkg::RowActs - 1));
                end
            end
            actValid <= 1'b0;
            actLast  <= 1'b0;
            // Idle gap, cluster must refuse activations here
            repeat (4) @(posedge clk);
        end
        // Drain forwarding and pending writes
        while (fwdQ.size() != 0 || deltaQ.size() != 0) @(posedge clk);
        repeat (2) @(posedge clk);
        $display("TEST PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* dv/pecTop_chk.sv */
// Column tracking assumes full 16-activation rows; timing checks are off while rst_n is low
`timescale 1ns/10ps
`default_nettype none

module pecTop_chk (
    input wire logic         clk,
    input wire logic         rst_n,
    input wire logic         wtReady,
    input wire logic         actValid,
    input wire logic         actReady,
    input wire logic         nxtValid,
    input wire pecPkg::vecT  nxtData,
    input wire logic         nxtLast,
    input wire logic         nxtReady,
    input wire logic         ramRdEn,
    input wire pecPkg::addrT ramRdAddr,
    input wire logic         ramWrEn
);

    pecPkg::colT colCnt;
    logic        fullAcc;

    // Accept that completes a full window
    assign fullAcc = actValid && actReady && (colCnt >= pecPkg::FirstOut);

    // Own column count, wraps after a row
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            colCnt <= '0;
        end else if (actValid && actReady) begin
            if (colCnt == pecPkg::LastCol) begin
                colCnt <= '0;
            end else begin
                colCnt <= colCnt + 1'b1;
            end
        end
    end

    // ========================================================================
    // Properties
    // ========================================================================

    // Idle handshake state in reset
    resetState: assert property (@(posedge clk)
        !rst_n |-> (wtReady && !actReady && !nxtValid && !ramRdEn && !ramWrEn))
        else $error("Handshake or RAM enables not idle while reset is asserted");

    // Read one cycle after a full-window accept
    readTiming: assert property (@(posedge clk) disable iff (!rst_n)
        ramRdEn == $past(fullAcc))
        else $error("RAM read enable does not follow a full-window accept by one cycle");

    // Read address is the output column of that window
    readAddr: assert property (@(posedge clk) disable iff (!rst_n)
        ramRdEn |-> (ramRdAddr == pecPkg::addrT'($past(colCnt) - pecPkg::FirstOut)))
        else $error("RAM read address is not the output column of the window");

    // Write exactly two cycles after it
    writeTiming: assert property (@(posedge clk) disable iff (!rst_n)
        ramWrEn == $past(fullAcc, 2))
        else $error("RAM write enable does not follow a full-window accept by two cycles");

    // Stalled output holds
    nxtHold: assert property (@(posedge clk) disable iff (!rst_n)
        (nxtValid && !nxtReady) |=> (nxtValid && $stable(nxtData) && $stable(nxtLast)))
        else $error("Next-cluster output changed or dropped while stalled");

endmodule

`default_nettype wire

/* dv/pecClkGen.sv */
// Free-running 10 ns clock; reset held low for the first 10 rising edges, released on an edge
`timescale 1ns/10ps
`default_nettype none

module pecClkGen (
    output logic clk,
    output logic rst_n
);

    // 100 MHz clock
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Reset for 10 cycles, released with the rising edge
    initial begin
        rst_n = 1'b0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

`default_nettype wire

/* verilog/pecTop.sv */
// One PE cluster; kernel flattened to 9 taps along the stream, write lags accept by 2 cycles
`timescale 1ns/10ps
`default_nettype none

module pecTop (
    input  wire logic           clk,
    input  wire logic           rst_n,
    // Weight load
    input  wire logic           wtValid,
    input  wire pecPkg::kernelT wtData,
    output logic                wtReady,
    // Activations in
    input  wire logic           actValid,
    input  wire pecPkg::vecT    actData,
    input  wire logic           actLast,
    output logic                actReady,
    // Activations to the next cluster
    output logic                nxtValid,
    output pecPkg::vecT         nxtData,
    output logic                nxtLast,
    input  wire logic           nxtReady,
    // Psum RAM
    output logic                ramRdEn,
    output pecPkg::addrT        ramRdAddr,
    input  wire pecPkg::psumT   ramRdData,
    output logic                ramWrEn,
    output pecPkg::addrT        ramWrAddr,
    output pecPkg::psumT        ramWrData
);

    // =========================================================================
    // Internal nets
    // =========================================================================
    logic                               weiLoaded;
    logic                               layerDone;
    logic                               tapValid;
    pecPkg::rowWeiT                     rowWei0;
    pecPkg::rowWeiT                     rowWei1;
    pecPkg::rowWeiT                     rowWei2;
    pecPkg::vecT [pecPkg::NumTaps-1:0]  window;
    pecPkg::psumT                       rowSum0;
    pecPkg::psumT                       rowSum1;
    pecPkg::psumT                       rowSum2;

    // =========================================================================
    // Submodules
    // =========================================================================

    weightRegs i_weightRegs (
        .clk(clk), .rst_n(rst_n),
        .wtValid(wtValid), .wtData(wtData), .wtReady(wtReady),
        .layerDone(layerDone), .weiLoaded(weiLoaded),
        .rowWei0(rowWei0), .rowWei1(rowWei1), .rowWei2(rowWei2)
    );

    actSequencer i_actSequencer (
        .clk(clk), .rst_n(rst_n),
        .actValid(actValid), .actData(actData), .actLast(actLast), .actReady(actReady),
        .nxtValid(nxtValid), .nxtData(nxtData), .nxtLast(nxtLast), .nxtReady(nxtReady),
        .weiLoaded(weiLoaded), .window(window), .tapValid(tapValid),
        .layerDone(layerDone)
    );

    // Row n sees window taps 3n to 3n+2
    convRow row0 (.clk(clk), .rst_n(rst_n), .taps(window[2:0]), .rowWei(rowWei0),
                  .rowSum(rowSum0));
    convRow row1 (.clk(clk), .rst_n(rst_n), .taps(window[5:3]), .rowWei(rowWei1),
                  .rowSum(rowSum1));
    convRow row2 (.clk(clk), .rst_n(rst_n), .taps(window[8:6]), .rowWei(rowWei2),
                  .rowSum(rowSum2));

    psumCtrl i_psumCtrl (
        .clk(clk), .rst_n(rst_n),
        .tapValid(tapValid),
        .rowSum0(rowSum0), .rowSum1(rowSum1), .rowSum2(rowSum2),
        .ramRdEn(ramRdEn), .ramRdAddr(ramRdAddr), .ramRdData(ramRdData),
        .ramWrEn(ramWrEn), .ramWrAddr(ramWrAddr), .ramWrData(ramWrData)
    );

endmodule

`default_nettype wire

/* verilog/psumCtrl.sv */
// Psum RAM must return read data one cycle after ramRdEn; no read-after-write bypass
`timescale 1ns/10ps
`default_nettype none

module psumCtrl (
    input  wire logic           clk,
    input  wire logic           rst_n,
    input  wire logic           tapValid,
    input  wire pecPkg::psumT   rowSum0,
    input  wire pecPkg::psumT   rowSum1,
    input  wire pecPkg::psumT   rowSum2,
    // Read port
    output logic                ramRdEn,
    output pecPkg::addrT        ramRdAddr,
    input  wire pecPkg::psumT   ramRdData,
    // Write port
    output logic                ramWrEn,
    output pecPkg::addrT        ramWrAddr,
    output pecPkg::psumT        ramWrData
);

    // =========================================================================
    // Read side
    // =========================================================================

    // One read per full window
    assign ramRdEn = tapValid;

    // Output column counter, wraps after OutCols
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ramRdAddr <= '0;
        end else if (ramRdEn) begin
            if (ramRdAddr == pecPkg::LastAddr) begin
                ramRdAddr <= '0;
            end else begin
                ramRdAddr <= ramRdAddr + 1'b1;
            end
        end
    end

    // =========================================================================
    // Write side
    // =========================================================================

    // Valid and address follow the read by one cycle,
    // lining up with read data and the row sums
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ramWrEn   <= 1'b0;
            ramWrAddr <= '0;
        end else begin
            ramWrEn   <= ramRdEn;
            ramWrAddr <= ramRdAddr;
        end
    end

    // Accumulate, wraps at PsumW
    assign ramWrData = ramRdData + rowSum0 + rowSum1 + rowSum2;

endmodule

`default_nettype wire

/* verilog/convRow.sv */
// One kernel row; result lags the window by one cycle and wraps at the psum width
`timescale 1ns/10ps
`default_nettype none

module convRow (
    input  wire logic                                   clk,
    input  wire logic                                   rst_n,
    input  wire pecPkg::vecT [pecPkg::KernelSize-1:0]   taps,
    input  wire pecPkg::rowWeiT                         rowWei,
    output pecPkg::psumT                                rowSum
);

    pecPkg::psumT rowAcc;

    // Three dot products of BlockDepth signed elements each
    always_comb begin
        pecPkg::elemT           act;
        pecPkg::elemT           wei;
        logic signed [2*pecPkg::DataW-1:0] prod;
        rowAcc = '0;
        for (int t = 0; t < pecPkg::KernelSize; t++) begin
            for (int e = 0; e < pecPkg::BlockDepth; e++) begin
                act    = taps[t][e*pecPkg::DataW +: pecPkg::DataW];
                wei    = rowWei[t][e*pecPkg::DataW +: pecPkg::DataW];
                // Full-width product, sign extended into the sum
                prod   = act * wei;
                rowAcc = rowAcc + pecPkg::psumT'(prod);
            end
        end
    end

    // Registered every cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rowSum <= '0;
        end else begin
            rowSum <= rowAcc;
        end
    end

endmodule

`default_nettype wire

/* verilog/actSequencer.sv */
// actLast must come only on the 16th activation of a row; column count assumes full rows
`timescale 1ns/10ps
`default_nettype none

module actSequencer (
    input  wire logic                                   clk,
    input  wire logic                                   rst_n,
    // Activations from the previous cluster
    input  wire logic                                   actValid,
    input  wire pecPkg::vecT                            actData,
    input  wire logic                                   actLast,
    output logic                                        actReady,
    // Hand-over to the next cluster
    output logic                                        nxtValid,
    output pecPkg::vecT                                 nxtData,
    output logic                                        nxtLast,
    input  wire logic                                   nxtReady,
    // Weight status
    input  wire logic                                   weiLoaded,
    // Compute side
    output pecPkg::vecT [pecPkg::NumTaps-1:0]           window,
    output logic                                        tapValid,
    output logic                                        layerDone
);

    logic        accept;
    pecPkg::colT colCnt;

    // =========================================================================
    // Input handshake
    // =========================================================================

    // Slot empty or being drained this cycle
    assign actReady  = weiLoaded && (!nxtValid || nxtReady);
    assign accept    = actValid && actReady;

    // Last activation of the layer releases the weights
    assign layerDone = accept && actLast;

    // =========================================================================
    // Forward slot
    // =========================================================================

    // Valid bit
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            nxtValid <= 1'b0;
        end else if (accept) begin
            nxtValid <= 1'b1;
        end else if (nxtReady) begin
            nxtValid <= 1'b0;
        end
    end

    // Payload, held while stalled
    always_ff @(posedge clk) begin
        if (accept) begin
            nxtData <= actData;
            nxtLast <= actLast;
        end
    end

    // =========================================================================
    // Sliding window and column count
    // =========================================================================

    // Newest activation enters at tap 8, oldest drops off tap 0
    always_ff @(posedge clk) begin
        if (accept) begin
            window <= {actData, window[pecPkg::NumTaps-1:1]};
        end
    end

    // Column within the row, wraps after RowActs
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            colCnt <= '0;
        end else if (accept) begin
            if (colCnt == pecPkg::LastCol) begin
                colCnt <= '0;
            end else begin
                colCnt <= colCnt + 1'b1;
            end
        end
    end

    // One pulse per full window, columns 8 to 15
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tapValid <= 1'b0;
        end else begin
            tapValid <= accept && (colCnt >= pecPkg::FirstOut);
        end
    end

endmodule

`default_nettype wire

/* verilog/weightRegs.sv */
// Holds one kernel per layer; a new kernel is taken only after layerDone clears the flag
`timescale 1ns/10ps
`default_nettype none

module weightRegs (
    input  wire logic           clk,
    input  wire logic           rst_n,
    input  wire logic           wtValid,
    input  wire pecPkg::kernelT wtData,
    output logic                wtReady,
    input  wire logic           layerDone,
    output logic                weiLoaded,
    output pecPkg::rowWeiT      rowWei0,
    output pecPkg::rowWeiT      rowWei1,
    output pecPkg::rowWeiT      rowWei2
);

    pecPkg::kernelT kernel;

    // Ready only while no kernel is held
    assign wtReady = !weiLoaded;

    // Loaded flag, set by a transfer and cleared at layer end
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            weiLoaded <= 1'b0;
        end else if (wtValid && wtReady) begin
            weiLoaded <= 1'b1;
        end else if (layerDone) begin
            weiLoaded <= 1'b0;
        end
    end

    // Kernel storage
    always_ff @(posedge clk) begin
        if (wtValid && wtReady) begin
            kernel <= wtData;
        end
    end

    // Row split, taps 0-2, 3-5, 6-8
    assign rowWei0 = kernel[2:0];
    assign rowWei1 = kernel[5:3];
    assign rowWei2 = kernel[8:6];

endmodule

`default_nettype wire

/* verilog/pecPkg.sv */
// Sizes fixed for a 3x3 kernel of 4-channel int8 vectors; psums wrap modulo 2^24
`default_nettype none

package pecPkg;

    // =========================================================================
    // Element and vector sizes
    // =========================================================================
    localparam int DataW      = 8;
    localparam int BlockDepth = 4;
    localparam int KernelSize = 3;
    localparam int NumTaps    = KernelSize * KernelSize;

    // Row geometry, 8 outputs need 16 activations through a 9-tap window
    localparam int OutCols = 8;
    localparam int RowActs = OutCols + NumTaps - 1;

    // Psum width and RAM addressing
    localparam int PsumW = 24;
    localparam int AddrW = 3;
    localparam int ColW  = $clog2(RowActs);

    // =========================================================================
    // Types
    // =========================================================================
    typedef logic signed [DataW-1:0]            elemT;
    typedef logic [BlockDepth*DataW-1:0]        vecT;
    typedef vecT [KernelSize-1:0]               rowWeiT;
    // Tap 0 sits in the low bits
    typedef vecT [NumTaps-1:0]                  kernelT;
    typedef logic signed [PsumW-1:0]            psumT;
    typedef logic [AddrW-1:0]                   addrT;
    typedef logic [ColW-1:0]                    colT;

    // Counter limits
    localparam addrT LastAddr = addrT'(OutCols - 1);
    localparam colT  LastCol  = colT'(RowActs - 1);
    // First column whose window is full
    localparam colT  FirstOut = colT'(NumTaps - 1);

endpackage

`default_nettype wire
